// ==== src/core_pkg.sv ====
package core_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_width = 5;

  // Fetch advances one word at a time
  localparam logic [xlen-1:0] pc_step = 4;

  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll     = 3'b001;
  localparam logic [2:0] funct3_slt     = 3'b010;
  localparam logic [2:0] funct3_sltu    = 3'b011;
  localparam logic [2:0] funct3_xor     = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_and     = 3'b111;

  // Selects sub and sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  typedef enum logic [1:0] {
    fwd_none     = 2'b00,
    fwd_from_mem = 2'b01,
    fwd_from_wb  = 2'b10
  } fwd_sel_t;

  typedef union packed {
    struct packed {
      logic [6:0]                funct7;
      logic [reg_addr_width-1:0] rs2;
      logic [reg_addr_width-1:0] rs1;
      logic [2:0]                funct3;
      logic [reg_addr_width-1:0] rd;
      logic [6:0]                opcode;
    } r;
    struct packed {
      logic [11:0]               imm12;
      logic [reg_addr_width-1:0] rs1;
      logic [2:0]                funct3;
      logic [reg_addr_width-1:0] rd;
      logic [6:0]                opcode;
    } i;
  } instr_t;

endpackage

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic [core_pkg::xlen-1:0] a,
  input  logic [core_pkg::xlen-1:0] b,
  input  core_pkg::alu_op_t         op,
  output logic [core_pkg::xlen-1:0] y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      core_pkg::alu_add: begin
        y = a + b;
      end
      core_pkg::alu_sub: begin
        y = a - b;
      end
      core_pkg::alu_sll: begin
        y = a << shamt;
      end
      core_pkg::alu_slt: begin
        y = {{(core_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
      end
      core_pkg::alu_sltu: begin
        y = {{(core_pkg::xlen-1){1'b0}}, a < b};
      end
      core_pkg::alu_xor: begin
        y = a ^ b;
      end
      core_pkg::alu_srl: begin
        y = a >> shamt;
      end
      core_pkg::alu_sra: begin
        y = $unsigned($signed(a) >>> shamt);
      end
      core_pkg::alu_or: begin
        y = a | b;
      end
      core_pkg::alu_and: begin
        y = a & b;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [core_pkg::reg_addr_width-1:0] rs1,
  input  logic [core_pkg::reg_addr_width-1:0] rs2,
  input  logic                                we,
  input  logic [core_pkg::reg_addr_width-1:0] wd_addr,
  input  logic [core_pkg::xlen-1:0]           wd_data,
  output logic [core_pkg::xlen-1:0]           rd1,
  output logic [core_pkg::xlen-1:0]           rd2
);

  // x0 has no storage
  logic [core_pkg::xlen-1:0] regs [1:31];

  // Write first, read after
  function automatic logic [core_pkg::xlen-1:0] read_port(
    input logic [core_pkg::reg_addr_width-1:0] addr
  );
    if (addr == '0) return '0;
    if (we && wd_addr == addr) return wd_data;
    return regs[addr];
  endfunction

  always_comb begin
    rd1 = read_port(rs1);
    rd2 = read_port(rs2);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int n = 1; n < 32; n++) regs[n] <= '0;
    end else if (we && wd_addr != '0) begin
      regs[wd_addr] <= wd_data;
    end
  end

endmodule

// ==== src/forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [core_pkg::reg_addr_width-1:0] ex_rs1,
  input  logic [core_pkg::reg_addr_width-1:0] ex_rs2,
  input  logic [core_pkg::reg_addr_width-1:0] mem_rd,
  input  logic                                mem_write,
  input  logic [core_pkg::reg_addr_width-1:0] wb_rd,
  input  logic                                wb_write,
  output core_pkg::fwd_sel_t                  fwd_a,
  output core_pkg::fwd_sel_t                  fwd_b
);

  // Youngest producer wins
  function automatic core_pkg::fwd_sel_t pick(
    input logic [core_pkg::reg_addr_width-1:0] rs
  );
    if (rs == '0) return core_pkg::fwd_none;
    if (mem_write && mem_rd == rs) return core_pkg::fwd_from_mem;
    if (wb_write && wb_rd == rs) return core_pkg::fwd_from_wb;
    return core_pkg::fwd_none;
  endfunction

  always_comb begin
    fwd_a = pick(ex_rs1);
    fwd_b = pick(ex_rs2);
  end

  assert property (@(posedge clock) disable iff (reset)
    fwd_a != 2'b11 && fwd_b != 2'b11);

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      hold,
  input  logic [core_pkg::xlen-1:0] inst,
  output logic [core_pkg::xlen-1:0] inst_addr,
  output logic [core_pkg::xlen-1:0] if_inst,
  output logic [core_pkg::xlen-1:0] if_pc,
  output logic                      if_valid
);

  logic [core_pkg::xlen-1:0] pc;
  // Address of the word the ROM returns this cycle
  logic [core_pkg::xlen-1:0] tag_pc;
  logic                      tag_valid;

  // Held cycle re-reads the word already in flight
  assign inst_addr = hold ? tag_pc : pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc        <= '0;
      tag_pc    <= '0;
      tag_valid <= 1'b0;
      if_valid  <= 1'b0;
    end else if (!hold) begin
      pc        <= pc + core_pkg::pc_step;
      tag_pc    <= pc;
      tag_valid <= 1'b1;
      if_valid  <= tag_valid;
    end
  end

  // IF/ID payload
  always_ff @(posedge clock) begin
    if (!hold) begin
      if_inst <= inst;
      if_pc   <= tag_pc;
    end
  end

  assert property (@(posedge clock) disable iff (reset) inst_addr[1:0] == 2'b00);

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                hold,
  input  logic [core_pkg::xlen-1:0]           if_inst,
  input  logic [core_pkg::xlen-1:0]           if_pc,
  input  logic                                if_valid,
  input  logic                                wb_write,
  input  logic [core_pkg::reg_addr_width-1:0] wb_rd,
  input  logic [core_pkg::xlen-1:0]           wb_data,
  output logic [core_pkg::reg_addr_width-1:0] ex_rs1,
  output logic [core_pkg::reg_addr_width-1:0] ex_rs2,
  output logic [core_pkg::xlen-1:0]           ex_op_a,
  output logic [core_pkg::xlen-1:0]           ex_op_b,
  output logic [core_pkg::xlen-1:0]           ex_imm,
  output logic                                ex_use_imm,
  output core_pkg::alu_op_t                   ex_alu_op,
  output logic [core_pkg::reg_addr_width-1:0] ex_rd,
  output logic                                ex_write
);

  core_pkg::instr_t          word;
  logic [core_pkg::xlen-1:0] rd1;
  logic [core_pkg::xlen-1:0] rd2;
  logic [core_pkg::xlen-1:0] imm;
  logic                      use_imm;
  logic                      supported;
  core_pkg::alu_op_t         alu_op;

  assign word = if_inst;

  function automatic core_pkg::alu_op_t map_op(input logic [2:0] funct3, input logic alt);
    case (funct3)
      core_pkg::funct3_add_sub: return alt ? core_pkg::alu_sub : core_pkg::alu_add;
      core_pkg::funct3_sll:     return core_pkg::alu_sll;
      core_pkg::funct3_slt:     return core_pkg::alu_slt;
      core_pkg::funct3_sltu:    return core_pkg::alu_sltu;
      core_pkg::funct3_xor:     return core_pkg::alu_xor;
      core_pkg::funct3_srl_sra: return alt ? core_pkg::alu_sra : core_pkg::alu_srl;
      core_pkg::funct3_or:      return core_pkg::alu_or;
      default:                  return core_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    imm       = {{(core_pkg::xlen-12){word.i.imm12[11]}}, word.i.imm12};
    use_imm   = 1'b0;
    supported = 1'b0;
    alu_op    = core_pkg::alu_add;
    case (word.r.opcode)
      core_pkg::opcode_op: begin
        supported = 1'b1;
        alu_op    = map_op(word.r.funct3, word.r.funct7 == core_pkg::funct7_alt);
      end
      core_pkg::opcode_op_imm: begin
        supported = 1'b1;
        use_imm   = 1'b1;
        // No subi, so only the shift reads the upper immediate bits
        alu_op    = map_op(word.i.funct3, word.i.funct3 == core_pkg::funct3_srl_sra &&
                           word.i.imm12[11:5] == core_pkg::funct7_alt);
        if (word.i.funct3 inside {core_pkg::funct3_sll, core_pkg::funct3_srl_sra})
          imm = {{(core_pkg::xlen-5){1'b0}}, word.i.imm12[4:0]};
      end
      default: ;
    endcase
  end

  register_file u_register_file (
    .clock   (clock),
    .reset   (reset),
    .rs1     (word.r.rs1),
    .rs2     (word.r.rs2),
    .we      (wb_write),
    .wd_addr (wb_rd),
    .wd_data (wb_data),
    .rd1     (rd1),
    .rd2     (rd2)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_write <= 1'b0;
    end else if (!hold) begin
      ex_write <= if_valid && supported && word.r.rd != '0;
    end
  end

  // ID/EX payload
  always_ff @(posedge clock) begin
    if (!hold) begin
      ex_rs1     <= word.r.rs1;
      ex_rs2     <= use_imm ? '0 : word.r.rs2;
      ex_op_a    <= rd1;
      ex_op_b    <= rd2;
      ex_imm     <= imm;
      ex_use_imm <= use_imm;
      ex_alu_op  <= alu_op;
      ex_rd      <= word.r.rd;
    end
  end

  // Without redirects, decode sees consecutive addresses
  assert property (@(posedge clock) disable iff (reset)
    if_valid && !hold |=> if_valid && if_pc == $past(if_pc) + core_pkg::pc_step);

endmodule

// ==== src/execute_retire.sv ====
`timescale 1ns/1ps

module execute_retire (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                hold,
  input  logic [core_pkg::reg_addr_width-1:0] ex_rs1,
  input  logic [core_pkg::reg_addr_width-1:0] ex_rs2,
  input  logic [core_pkg::xlen-1:0]           ex_op_a,
  input  logic [core_pkg::xlen-1:0]           ex_op_b,
  input  logic [core_pkg::xlen-1:0]           ex_imm,
  input  logic                                ex_use_imm,
  input  core_pkg::alu_op_t                   ex_alu_op,
  input  logic [core_pkg::reg_addr_width-1:0] ex_rd,
  input  logic                                ex_write,
  output logic                                wb_write,
  output logic [core_pkg::reg_addr_width-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]           wb_data
);

  core_pkg::fwd_sel_t                  fwd_a;
  core_pkg::fwd_sel_t                  fwd_b;
  logic [core_pkg::xlen-1:0]           src_a;
  logic [core_pkg::xlen-1:0]           src_b;
  logic [core_pkg::xlen-1:0]           alu_y;
  logic [core_pkg::xlen-1:0]           mem_result;
  logic [core_pkg::reg_addr_width-1:0] mem_rd;
  logic                                mem_write;
  logic                                wb_write_q;
  // Low after a held edge, so one result retires once
  logic                                wb_fresh;

  function automatic logic [core_pkg::xlen-1:0] pick_operand(
    input core_pkg::fwd_sel_t        sel,
    input logic [core_pkg::xlen-1:0] reg_value
  );
    case (sel)
      core_pkg::fwd_from_mem: return mem_result;
      core_pkg::fwd_from_wb:  return wb_data;
      default:                return reg_value;
    endcase
  endfunction

  forwarding_unit u_forwarding_unit (
    .clock     (clock),
    .reset     (reset),
    .ex_rs1    (ex_rs1),
    .ex_rs2    (ex_rs2),
    .mem_rd    (mem_rd),
    .mem_write (mem_write),
    .wb_rd     (wb_rd),
    .wb_write  (wb_write_q),
    .fwd_a     (fwd_a),
    .fwd_b     (fwd_b)
  );

  always_comb begin
    src_a = pick_operand(fwd_a, ex_op_a);
    src_b = ex_use_imm ? ex_imm : pick_operand(fwd_b, ex_op_b);
  end

  alu u_alu (
    .a  (src_a),
    .b  (src_b),
    .op (ex_alu_op),
    .y  (alu_y)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_write  <= 1'b0;
      wb_write_q <= 1'b0;
      wb_fresh   <= 1'b0;
    end else begin
      wb_fresh <= !hold;
      if (!hold) begin
        mem_write  <= ex_write;
        wb_write_q <= mem_write;
      end
    end
  end

  // EX/MEM and MEM/WB payload
  always_ff @(posedge clock) begin
    if (!hold) begin
      mem_result <= alu_y;
      mem_rd     <= ex_rd;
      wb_data    <= mem_result;
      wb_rd      <= mem_rd;
    end
  end

  assign wb_write = wb_write_q && wb_fresh;

  // Decode already drops rd of x0
  assert property (@(posedge clock) disable iff (reset) wb_write |-> wb_rd != '0);

endmodule

// ==== src/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                hold,
  input  logic [core_pkg::xlen-1:0]           inst,
  output logic [core_pkg::xlen-1:0]           inst_addr,
  output logic                                wb_en,
  output logic [core_pkg::reg_addr_width-1:0] wb_rd,
  output logic [core_pkg::xlen-1:0]           wb_data
);

  logic [core_pkg::xlen-1:0]           if_inst;
  logic [core_pkg::xlen-1:0]           if_pc;
  logic                                if_valid;
  logic [core_pkg::reg_addr_width-1:0] ex_rs1;
  logic [core_pkg::reg_addr_width-1:0] ex_rs2;
  logic [core_pkg::xlen-1:0]           ex_op_a;
  logic [core_pkg::xlen-1:0]           ex_op_b;
  logic [core_pkg::xlen-1:0]           ex_imm;
  logic                                ex_use_imm;
  core_pkg::alu_op_t                   ex_alu_op;
  logic [core_pkg::reg_addr_width-1:0] ex_rd;
  logic                                ex_write;

  fetch_stage u_fetch_stage (
    .clock     (clock),
    .reset     (reset),
    .hold      (hold),
    .inst      (inst),
    .inst_addr (inst_addr),
    .if_inst   (if_inst),
    .if_pc     (if_pc),
    .if_valid  (if_valid)
  );

  // Retire port also writes the register file
  decode_stage u_decode_stage (
    .clock      (clock),
    .reset      (reset),
    .hold       (hold),
    .if_inst    (if_inst),
    .if_pc      (if_pc),
    .if_valid   (if_valid),
    .wb_write   (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .ex_rs1     (ex_rs1),
    .ex_rs2     (ex_rs2),
    .ex_op_a    (ex_op_a),
    .ex_op_b    (ex_op_b),
    .ex_imm     (ex_imm),
    .ex_use_imm (ex_use_imm),
    .ex_alu_op  (ex_alu_op),
    .ex_rd      (ex_rd),
    .ex_write   (ex_write)
  );

  execute_retire u_execute_retire (
    .clock      (clock),
    .reset      (reset),
    .hold       (hold),
    .ex_rs1     (ex_rs1),
    .ex_rs2     (ex_rs2),
    .ex_op_a    (ex_op_a),
    .ex_op_b    (ex_op_b),
    .ex_imm     (ex_imm),
    .ex_use_imm (ex_use_imm),
    .ex_alu_op  (ex_alu_op),
    .ex_rd      (ex_rd),
    .ex_write   (ex_write),
    .wb_write   (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

// ==== bench/rv_model.svh ====
// Random program generator and in-order reference model

function automatic logic [4:0] pick_reg();
  int r;
  r = $random(seed);
  return 5'($unsigned(r) % 6);
endfunction

function automatic bit coin();
  return ($random(seed) & 1) == 1;
endfunction

function automatic logic [31:0] random_instr();
  int sel;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [6:0] bad_op;
  logic [11:0] imm;
  sel = $unsigned($random(seed)) % 100;
  f3 = 3'($random(seed));
  imm = 12'($random(seed));
  if (sel < 5) begin
    // Load, store, branch and jal opcodes are not executed
    case ($unsigned($random(seed)) % 4)
      0: bad_op = 7'b0000011;
      1: bad_op = 7'b0100011;
      2: bad_op = 7'b1100011;
      default: bad_op = 7'b1101111;
    endcase
    return {imm, pick_reg(), f3, pick_reg(), bad_op};
  end
  if (sel < 50) begin
    f7 = 7'b0000000;
    if ((f3 == 3'b000 || f3 == 3'b101) && coin())
      f7 = 7'b0100000;
    return {f7, pick_reg(), pick_reg(), f3, pick_reg(), 7'b0110011};
  end
  if (f3 == 3'b001)
    imm[11:5] = 7'b0000000;
  if (f3 == 3'b101)
    imm[11:5] = coin() ? 7'b0100000 : 7'b0000000;
  return {imm, pick_reg(), f3, pick_reg(), 7'b0010011};
endfunction

function automatic logic [31:0] model_exec(
  input logic [2:0]  f3,
  input logic        alt,
  input logic [31:0] a,
  input logic [31:0] b
);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return {31'b0, $signed(a) < $signed(b)};
    3'b011: return {31'b0, a < b};
    3'b100: return a ^ b;
    3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic build_expected();
  logic [31:0] mregs [32];
  logic [31:0] w;
  logic [31:0] b;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic        alt;
  bit          valid;
  bit          is_r;
  bit          dep;
  int          last1;
  int          last2;
  last1 = -1;
  last2 = -1;
  for (int n = 0; n < 32; n++) mregs[n] = '0;
  for (int n = 0; n < prog_len; n++) begin
    w = rom[n];
    rd = w[11:7];
    rs1 = w[19:15];
    rs2 = w[24:20];
    valid = 1'b1;
    is_r = 1'b0;
    alt = 1'b0;
    b = '0;
    if (w[6:0] == 7'b0110011) begin
      is_r = 1'b1;
      b = mregs[rs2];
      alt = w[30];
    end else if (w[6:0] == 7'b0010011) begin
      b = {{20{w[31]}}, w[31:20]};
      alt = (w[14:12] == 3'b101) && w[30];
    end else begin
      valid = 1'b0;
    end
    // Producer one or two slots back
    dep = rs1 != 0 && (int'(rs1) == last1 || int'(rs1) == last2);
    if (is_r && rs2 != 0 && (int'(rs2) == last1 || int'(rs2) == last2))
      dep = 1'b1;
    last2 = last1;
    last1 = -1;
    if (valid && rd != 0) begin
      mregs[rd] = model_exec(w[14:12], alt, mregs[rs1], b);
      exp_rd.push_back(rd);
      exp_val.push_back(mregs[rd]);
      exp_kind.push_back(is_r ? 0 : 1);
      exp_dep.push_back(dep);
      last1 = int'(rd);
    end
  end
endtask

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

  localparam int prog_len = 300;
  localparam int reset_cycles = 4;
  localparam int drain_cycles = 20;
  localparam logic [31:0] nop_word = 32'h00000013;

  logic        clock;
  logic        reset;
  logic        hold;
  logic [31:0] inst;
  logic [31:0] inst_addr;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;

  int seed = 32'h0d6922d5;
  logic [31:0] rom [prog_len];

  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];
  int          exp_kind [$];
  bit          exp_dep [$];

  bit held_at_edge;
  bit running;
  bit reset_window;
  int total_expected;
  int retired;
  int reset_checked;
  int reset_err;
  int r_checked;
  int r_err;
  int i_checked;
  int i_err;
  int dep_checked;
  int dep_err;
  int hold_cycles;
  int hold_err;
  int extra_err;

  `include "rv_model.svh"

  riscv_core u_riscv_core (
    .clock     (clock),
    .reset     (reset),
    .hold      (hold),
    .inst      (inst),
    .inst_addr (inst_addr),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  function automatic logic [31:0] rom_word(input logic [31:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog_len) return rom[idx];
    return nop_word;
  endfunction

  // Synchronous ROM and random freeze
  always @(posedge clock) begin
    held_at_edge <= hold;
    if (hold) hold_cycles++;
    inst <= rom_word(inst_addr);
    if (running) hold <= ($random(seed) & 7) == 0;
    else hold <= 1'b0;
  end

  always @(negedge clock) begin
    if (reset_window) begin
      reset_checked++;
      if (wb_en !== 1'b0 || inst_addr !== 32'h0) begin
        reset_err++;
        $display("Mismatch at %0t: around reset wb_en=%b inst_addr=%h", $time, wb_en, inst_addr);
      end
    end
    if (!reset && wb_en === 1'b1) begin
      retired++;
      if (held_at_edge) begin
        hold_err++;
        $display("Retirement at %0t in the cycle right after a held edge", $time);
      end
      if (exp_rd.size() == 0) begin
        extra_err++;
        $display("Unexpected retirement at %0t to x%0d beyond the model's count", $time, wb_rd);
      end else begin
        if (exp_kind[0] == 0) r_checked++;
        else i_checked++;
        if (exp_dep[0]) dep_checked++;
        if (wb_rd !== exp_rd[0] || wb_data !== exp_val[0]) begin
          if (exp_kind[0] == 0) r_err++;
          else i_err++;
          if (exp_dep[0]) dep_err++;
          $display("Mismatch at %0t: expected x%0d=%h, got x%0d=%h",
                   $time, exp_rd[0], exp_val[0], wb_rd, wb_data);
        end
        void'(exp_rd.pop_front());
        void'(exp_val.pop_front());
        void'(exp_kind.pop_front());
        void'(exp_dep.pop_front());
      end
    end
  end

  initial begin
    int count_err;
    int errors;
    reset = 1'b1;
    hold = 1'b0;
    inst = nop_word;
    running = 1'b0;
    reset_window = 1'b1;
    for (int n = 0; n < prog_len; n++) rom[n] = random_instr();
    build_expected();
    total_expected = exp_rd.size();
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
    running <= 1'b1;
    @(posedge clock);
    reset_window = 1'b0;
    $display("test 1 reset: %0d cycles checked, %0d errors", reset_checked, reset_err);
    while (exp_rd.size() > 0) @(posedge clock);
    // Catch stray retirements after the last one
    repeat (drain_cycles) @(posedge clock);
    count_err = extra_err + ((retired != total_expected) ? 1 : 0);
    $display("test 2 R-type: %0d checked, %0d errors", r_checked, r_err);
    $display("test 3 I-type: %0d checked, %0d errors", i_checked, i_err);
    $display("test 4 forwarding: %0d dependent checked, %0d errors", dep_checked, dep_err);
    $display("test 5 hold: %0d held cycles, %0d errors", hold_cycles, hold_err);
    $display("test 6 retire count: %0d of %0d expected, %0d errors",
             retired, total_expected, count_err);
    errors = reset_err + r_err + i_err + hold_err + count_err;
    $display("checks %0d, errors %0d", reset_checked + r_checked + i_checked + 1, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (600 + prog_len * 2) @(posedge clock);
    $display("Timeout: %0d of %0d expected retirements seen", retired, total_expected);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+bench
src/core_pkg.sv
src/alu.sv
src/register_file.sv
src/forwarding_unit.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_retire.sv
src/riscv_core.sv
bench/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module core_tb -o core_tb; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/core_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
